// File: source/umi_defs.svh
`ifndef UMI_DEFS_SVH
`define UMI_DEFS_SVH

// Link widths
`define UMI_AW 16                                   // Address
`define UMI_DW 32                                   // Data word
`define UMI_CW 7                                    // Command field
`define UMI_UW 80                                   // Whole packet

// Field offsets with the command in the low bits
`define UMI_DST_LSB  `UMI_CW
`define UMI_SRC_LSB  (`UMI_DST_LSB + `UMI_AW)
`define UMI_DATA_LSB (`UMI_SRC_LSB + `UMI_AW)

// Endpoint sizing
`define UMI_MEM_WORDS 64                            // Indexed by dstaddr[7:2]
`define UMI_CREDITS   2                             // Response credits after reset

`endif

// File: source/umi_pkt_pkg.sv
`include "umi_defs.svh"

package umi_pkt_pkg;

   //######################################
   // Packet fields
   //######################################

   typedef logic [`UMI_AW-1:0] umi_addr_t;          // dstaddr and srcaddr
   typedef logic [`UMI_DW-1:0] umi_data_t;          // One memory word
   typedef logic [`UMI_UW-1:0] umi_packet_t;        // Full link packet

   //######################################
   // Command codes
   //######################################

   // Requests are odd, responses even
   typedef enum logic [`UMI_CW-1:0] {
      CMD_READ         = 7'h01,                     // Read one word
      CMD_WRITE_ACK    = 7'h03,                     // Write with ack
      CMD_WRITE_POSTED = 7'h05,                     // Fire and forget
      CMD_ATOMIC_ADD   = 7'h09,                     // Fetch and add
      CMD_ATOMIC_SWAP  = 7'h0b,                     // Fetch and store
      CMD_RESP_READ    = 7'h02,                     // Carries a data word
      CMD_RESP_ACK     = 7'h04                      // Write ack, no data
   } umi_cmd_t;

endpackage

// File: source/umi_ctrl_pkg.sv
package umi_ctrl_pkg;

   // Endpoint sequencing
   typedef enum logic [1:0] {
      EP_IDLE    = 2'd0,                            // Waiting for a request
      EP_ACCESS  = 2'd1,                            // Memory cycle
      EP_RESPOND = 2'd2                             // Response on the link
   } ep_state_t;

   // What the memory does at the end of the access cycle
   typedef enum logic [1:0] {
      MEM_NONE  = 2'd0,                             // Read only or no-op
      MEM_WRITE = 2'd1,                             // Store wdata
      MEM_ADD   = 2'd2,                             // Store old + wdata
      MEM_SWAP  = 2'd3                              // Store wdata, return old
   } mem_op_t;

endpackage

// File: source/umi_request_decode.sv
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_request_decode
   import umi_pkt_pkg::*, umi_ctrl_pkg::*;
(
   input  umi_packet_t packet,
   output umi_cmd_t    cmd,
   output umi_addr_t   dstaddr,
   output umi_addr_t   srcaddr,
   output umi_data_t   wdata,
   output mem_op_t     mem_op,
   output logic        needs_resp,
   output logic        cmd_valid_op
);

   //######################################
   // Field slicing
   //######################################

   assign cmd     = umi_cmd_t'(packet[`UMI_CW-1:0]);          // Raw code, may be unlisted
   assign dstaddr = packet[`UMI_DST_LSB +: `UMI_AW];          // Local word address
   assign srcaddr = packet[`UMI_SRC_LSB +: `UMI_AW];          // Where the response goes
   assign wdata   = packet[`UMI_DATA_LSB +: `UMI_DW];         // Write or atomic operand

   //######################################
   // Command classification
   //######################################

   always_comb
   begin
      mem_op       = MEM_NONE;
      needs_resp   = 1'b0;
      cmd_valid_op = 1'b1;
      case (cmd)
         CMD_READ:
            needs_resp = 1'b1;                                 // Old word returned
         CMD_WRITE_POSTED:
            mem_op = MEM_WRITE;                                // No response, no credit
         CMD_WRITE_ACK:
         begin
            mem_op     = MEM_WRITE;
            needs_resp = 1'b1;                                 // Ack only
         end
         CMD_ATOMIC_ADD:
         begin
            mem_op     = MEM_ADD;
            needs_resp = 1'b1;
         end
         CMD_ATOMIC_SWAP:
         begin
            mem_op     = MEM_SWAP;
            needs_resp = 1'b1;
         end
         default:
            cmd_valid_op = 1'b0;                               // Responses and unknown codes
      endcase
   end

endmodule

// File: source/umi_credit_counter.sv
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_credit_counter
(
   input  logic clk,
   input  logic nreset,
   input  logic credit_take,                        // Response sent this cycle
   input  logic credit_return,                      // Receiver freed one slot
   output logic credit_avail
);

   localparam int CNTW = $clog2(`UMI_CREDITS + 1);

   logic [CNTW-1:0] count;                          // Credits held by the endpoint

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         count <= CNTW'(`UMI_CREDITS);              // Receiver starts with free slots
      else if (credit_take && !credit_return)
         count <= count - 1'b1;
      else if (credit_return && !credit_take)
         count <= count + 1'b1;
      // Take and return together cancel out
   end

   assign credit_avail = (count != '0);

   //######################################
   // Link protocol checks
   //######################################

   // Receiver never hands back more than it was given
   a_credit_max: assert property (@(posedge clk) disable iff (!nreset)
      count <= CNTW'(`UMI_CREDITS));

   // FSM only responds when a credit was reserved at accept
   a_credit_underflow: assert property (@(posedge clk) disable iff (!nreset)
      credit_take |-> (count != '0) || credit_return);

endmodule

// File: source/umi_endpoint_fsm.sv
`timescale 1ns/1ps

module umi_endpoint_fsm
   import umi_ctrl_pkg::*;
(
   input  logic    clk,
   input  logic    nreset,
   input  logic    req_valid,
   output logic    req_ready,
   input  logic    cmd_valid_op,                    // From decoder
   input  logic    needs_resp,
   input  mem_op_t mem_op_in,
   input  logic    credit_avail,                    // From credit counter
   output logic    credit_take,
   output logic    mem_en,                          // High for the access cycle
   output mem_op_t mem_op,                          // Latched at accept
   output logic    capture,                         // Packer loads response
   output logic    resp_valid
);

   ep_state_t state;
   ep_state_t state_nxt;
   logic      armed;                                // Set on first edge out of reset
   logic      resp_due;                             // Accepted request wants an answer
   logic      accept;

   // Posted writes and junk commands pass without a credit
   assign req_ready = armed && (state == EP_IDLE) && (!needs_resp || credit_avail);
   assign accept    = req_valid && req_ready;

   //######################################
   // Next state
   //######################################

   always_comb
   begin
      state_nxt = state;
      case (state)
         EP_IDLE:
            if (accept)
               state_nxt = EP_ACCESS;
         EP_ACCESS:
            state_nxt = resp_due ? EP_RESPOND : EP_IDLE;
         EP_RESPOND:
            state_nxt = EP_IDLE;                    // One beat per response
         default:
            state_nxt = EP_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state    <= EP_IDLE;
         armed    <= 1'b0;
         resp_due <= 1'b0;
         mem_op   <= MEM_NONE;
      end
      else
      begin
         state <= state_nxt;
         armed <= 1'b1;
         if (accept)
         begin
            resp_due <= cmd_valid_op && needs_resp;
            mem_op   <= cmd_valid_op ? mem_op_in : MEM_NONE;   // Invalid is a no-op
         end
      end
   end

   assign mem_en      = (state == EP_ACCESS);
   assign capture     = mem_en && resp_due;         // Old word ready at end of access
   assign resp_valid  = (state == EP_RESPOND);
   assign credit_take = resp_valid;                 // Every beat uses one slot

   // A response beat always traces back to an accept that saw a credit
   a_resp_had_credit: assert property (@(posedge clk) disable iff (!nreset)
      resp_valid |-> $past(accept && credit_avail, 2));

endmodule

// File: source/umi_atomic_mem.sv
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_atomic_mem
   import umi_pkt_pkg::*, umi_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      mem_en,
   input  mem_op_t   op,
   input  umi_addr_t addr,
   input  umi_data_t wdata,
   output umi_data_t rdata                          // Word before this access
);

   localparam int IW = $clog2(`UMI_MEM_WORDS);

   umi_data_t     mem [`UMI_MEM_WORDS];
   logic [IW-1:0] idx_q;                            // Word index of current request
   umi_data_t     wdata_q;                          // Operand of current request

   // Track the decoder while idle and freeze once the access starts,
   // so the source may move on to its next packet
   always_ff @(posedge clk)
   begin
      if (!mem_en)
      begin
         idx_q   <= addr[IW+1:2];                   // Byte address to word index
         wdata_q <= wdata;
      end
   end

   assign rdata = mem[idx_q];                       // Asynchronous read

   //######################################
   // Read-modify-write
   //######################################

   always_ff @(posedge clk)
   begin
      if (mem_en)
      begin
         case (op)
            MEM_WRITE,
            MEM_SWAP:
               mem[idx_q] <= wdata_q;
            MEM_ADD:
               mem[idx_q] <= rdata + wdata_q;       // Wraps at 2^32
            default:
               ;                                    // Plain read
         endcase
      end
   end

endmodule

// File: source/umi_response_pack.sv
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_response_pack
   import umi_pkt_pkg::*;
(
   input  logic        clk,
   input  logic        capture,
   input  umi_cmd_t    cmd,
   input  umi_addr_t   dstaddr,
   input  umi_addr_t   srcaddr,
   input  umi_data_t   rdata,
   output umi_packet_t resp_packet
);

   localparam int PADW = `UMI_UW - `UMI_DATA_LSB - `UMI_DW;   // Zero fill on top

   umi_cmd_t  req_cmd;                              // Request fields held for the access
   umi_addr_t req_dst;
   umi_addr_t req_src;
   umi_cmd_t  resp_cmd;
   umi_addr_t resp_dst;
   umi_addr_t resp_src;
   umi_data_t resp_data;
   logic      is_ack;

   // Same hold scheme as the memory index
   always_ff @(posedge clk)
   begin
      if (!capture)
      begin
         req_cmd <= cmd;
         req_dst <= dstaddr;
         req_src <= srcaddr;
      end
   end

   assign is_ack = (req_cmd == CMD_WRITE_ACK);

   //######################################
   // Turn around
   //######################################

   always_ff @(posedge clk)
   begin
      if (capture)
      begin
         resp_cmd  <= is_ack ? CMD_RESP_ACK : CMD_RESP_READ;
         resp_dst  <= req_src;                      // Back to the requester
         resp_src  <= req_dst;
         resp_data <= is_ack ? '0 : rdata;          // Old word for reads and atomics
      end
   end

   assign resp_packet = {{PADW{1'b0}}, resp_data, resp_src, resp_dst, resp_cmd};

endmodule

// File: source/umi_endpoint.sv
`timescale 1ns/1ps

module umi_endpoint
   import umi_pkt_pkg::*, umi_ctrl_pkg::*;
(
   input  logic        clk,
   input  logic        nreset,
   input  logic        req_valid,
   input  umi_packet_t req_packet,
   output logic        req_ready,
   output logic        resp_valid,
   output umi_packet_t resp_packet,
   input  logic        resp_credit
);

   umi_cmd_t  cmd;
   umi_addr_t dstaddr;
   umi_addr_t srcaddr;
   umi_data_t wdata;
   umi_data_t rdata;
   mem_op_t   dec_mem_op;                           // Decoded, live
   mem_op_t   mem_op;                               // Latched by FSM
   logic      needs_resp;
   logic      cmd_valid_op;
   logic      credit_avail;
   logic      credit_take;
   logic      mem_en;
   logic      capture;

   //######################################
   // Request side
   //######################################

   umi_request_decode u_decode (
      .packet       (req_packet),
      .cmd          (cmd),
      .dstaddr      (dstaddr),
      .srcaddr      (srcaddr),
      .wdata        (wdata),
      .mem_op       (dec_mem_op),
      .needs_resp   (needs_resp),
      .cmd_valid_op (cmd_valid_op)
   );

   umi_endpoint_fsm u_fsm (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .cmd_valid_op (cmd_valid_op),
      .needs_resp   (needs_resp),
      .mem_op_in    (dec_mem_op),
      .credit_avail (credit_avail),
      .credit_take  (credit_take),
      .mem_en       (mem_en),
      .mem_op       (mem_op),
      .capture      (capture),
      .resp_valid   (resp_valid)
   );

   umi_atomic_mem u_mem (
      .clk          (clk),
      .mem_en       (mem_en),
      .op           (mem_op),
      .addr         (dstaddr),
      .wdata        (wdata),
      .rdata        (rdata)
   );

   //######################################
   // Response side
   //######################################

   umi_response_pack u_pack (
      .clk          (clk),
      .capture      (capture),
      .cmd          (cmd),
      .dstaddr      (dstaddr),
      .srcaddr      (srcaddr),
      .rdata        (rdata),
      .resp_packet  (resp_packet)
   );

   umi_credit_counter u_credit (
      .clk           (clk),
      .nreset        (nreset),
      .credit_take   (credit_take),
      .credit_return (resp_credit),                 // One credit per high cycle
      .credit_avail  (credit_avail)
   );

endmodule

// File: dv/tb_umi_endpoint.sv
`timescale 1ns/1ps
`include "umi_defs.svh"

module tb_umi_endpoint
   import umi_pkt_pkg::*;
();

   localparam int CLK_PERIOD     = 10;
   localparam int RESET_CYCLES   = 5;
   // About 40 transactions of under 10 cycles each, plus stall windows
   localparam int TIMEOUT_CYCLES = 2000;

   logic        clk;
   logic        nreset;
   logic        req_valid;
   umi_packet_t req_packet;
   logic        req_ready;
   logic        resp_valid;
   umi_packet_t resp_packet;
   logic        resp_credit;

   umi_data_t   model_mem [`UMI_MEM_WORDS];         // Expected memory contents
   int          cycle_count = 0;                    // Rising edges so far
   int          accept_cycle;                       // Edge count at last accept
   umi_packet_t last_resp;                          // Packet seen with resp_valid

   umi_endpoint UUT (
      .clk         (clk),
      .nreset      (nreset),
      .req_valid   (req_valid),
      .req_packet  (req_packet),
      .req_ready   (req_ready),
      .resp_valid  (resp_valid),
      .resp_packet (resp_packet),
      .resp_credit (resp_credit)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
         $display("Verification failed");
         $fatal(1, "Timeout");
      end
   end

   //######################################
   // Checks
   //######################################

   task automatic fail_run(input string what);
      $display("Error at %0d ns: %s", $time, what);
      $display("Verification failed");
      $fatal(1, "%s", what);
   endtask

   task automatic check_cmd(input string name, input umi_cmd_t got, input umi_cmd_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic check_addr(input string name, input umi_addr_t got, input umi_addr_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic check_data(input string name, input umi_data_t got, input umi_data_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   //######################################
   // Link helpers
   //######################################

   function automatic umi_packet_t make_pkt(input umi_cmd_t cmd, input umi_addr_t dst,
                                            input umi_addr_t src, input umi_data_t data);
      umi_packet_t pkt;
      pkt                           = '0;           // Top padding stays zero
      pkt[`UMI_CW-1:0]              = cmd;
      pkt[`UMI_DST_LSB +: `UMI_AW]  = dst;
      pkt[`UMI_SRC_LSB +: `UMI_AW]  = src;
      pkt[`UMI_DATA_LSB +: `UMI_DW] = data;
      return pkt;
   endfunction

   function automatic umi_addr_t word_addr(input int idx);
      umi_addr_t addr;
      addr      = umi_addr_t'($urandom());          // Upper and byte bits ignored
      addr[7:2] = idx[5:0];
      return addr;
   endfunction

   // Holds the request until the endpoint takes it
   task automatic send_req(input umi_packet_t pkt);
      logic taken;
      taken = 1'b0;
      @(negedge clk);
      req_valid  = 1'b1;
      req_packet = pkt;
      while (!taken)
      begin
         #1;                                        // Ready settled after the drive
         taken = req_ready;
         @(negedge clk);
      end
      accept_cycle = cycle_count;                   // Includes the accepting edge
      req_valid    = 1'b0;
   endtask

   task automatic wait_resp(input bit give_credit);
      @(negedge clk);
      while (!resp_valid)
      begin
         if (cycle_count - accept_cycle > 4)
            fail_run("No response to an accepted request");
         @(negedge clk);
      end
      if (cycle_count - accept_cycle != 1)
         fail_run("Response not seen at the second edge after acceptance");
      last_resp = resp_packet;
      @(negedge clk);
      if (resp_valid)
         fail_run("resp_valid held for more than one cycle");
      if (give_credit)
      begin
         resp_credit = 1'b1;                        // One cycle, one credit
         @(negedge clk);
         resp_credit = 1'b0;
      end
   endtask

   // Response goes back to the requester with the addresses swapped
   task automatic check_resp(input umi_cmd_t exp_cmd, input umi_addr_t req_dst,
                             input umi_addr_t req_src, input umi_data_t exp_data);
      check_cmd("resp cmd", umi_cmd_t'(last_resp[`UMI_CW-1:0]), exp_cmd);
      check_addr("resp dstaddr", last_resp[`UMI_DST_LSB +: `UMI_AW], req_src);
      check_addr("resp srcaddr", last_resp[`UMI_SRC_LSB +: `UMI_AW], req_dst);
      check_data("resp data", last_resp[`UMI_DATA_LSB +: `UMI_DW], exp_data);
      if (last_resp[`UMI_UW-1:`UMI_DATA_LSB+`UMI_DW] != '0)
         fail_run("Response padding bits not zero");
   endtask

   task automatic post_write(input umi_addr_t addr, input umi_data_t data);
      send_req(make_pkt(CMD_WRITE_POSTED, addr, umi_addr_t'($urandom()), data));
      model_mem[addr[7:2]] = data;
   endtask

   task automatic read_check(input umi_addr_t addr, input bit give_credit);
      umi_addr_t src;
      src = umi_addr_t'($urandom());
      send_req(make_pkt(CMD_READ, addr, src, umi_data_t'($urandom())));   // Data ignored
      wait_resp(give_credit);
      check_resp(CMD_RESP_READ, addr, src, model_mem[addr[7:2]]);
   endtask

   //######################################
   // Directed tests
   //######################################

   task automatic test_write_read();
      umi_addr_t addrs [8];
      for (int i = 0; i < 8; i++)
      begin
         addrs[i] = word_addr(i * 7 + 1);           // Spread over the array
         post_write(addrs[i], umi_data_t'($urandom()));
      end
      for (int i = 0; i < 8; i++)
         read_check(addrs[i], 1'b1);
   endtask

   task automatic test_ack_write();
      umi_addr_t addr;
      umi_addr_t src;
      umi_data_t data;
      addr = word_addr(20);
      src  = umi_addr_t'($urandom());
      data = $urandom();
      send_req(make_pkt(CMD_WRITE_ACK, addr, src, data));
      model_mem[addr[7:2]] = data;
      wait_resp(1'b1);
      check_resp(CMD_RESP_ACK, addr, src, '0);      // Ack carries no data
      read_check(addr, 1'b1);
   endtask

   task automatic test_atomic(input umi_cmd_t cmd, input int idx);
      umi_addr_t addr;
      umi_addr_t src;
      umi_data_t old;
      umi_data_t operand;
      addr    = word_addr(idx);
      src     = umi_addr_t'($urandom());
      operand = $urandom();
      post_write(addr, 32'hffff_fff0);              // Near the top so a sum wraps
      old = model_mem[addr[7:2]];
      send_req(make_pkt(cmd, addr, src, operand));
      if (cmd == CMD_ATOMIC_ADD)
         model_mem[addr[7:2]] = old + operand;      // Modulo 2^32
      else
         model_mem[addr[7:2]] = operand;
      wait_resp(1'b1);
      check_resp(CMD_RESP_READ, addr, src, old);    // Old word comes back
      read_check(addr, 1'b1);
   endtask

   task automatic test_backpressure();
      umi_addr_t addr;
      umi_addr_t src;
      umi_data_t data;
      read_check(word_addr(1), 1'b0);               // Both credits used up
      read_check(word_addr(8), 1'b0);
      addr = word_addr(60);
      src  = umi_addr_t'($urandom());
      @(negedge clk);
      req_valid  = 1'b1;
      req_packet = make_pkt(CMD_READ, addr, src, '0);
      repeat (10)
      begin
         #1;
         if (req_ready)
            fail_run("req_ready high for a read while no credits are held");
         @(negedge clk);
      end
      data = $urandom();
      post_write(addr, data);                       // Needs no credit
      resp_credit = 1'b1;
      @(negedge clk);
      resp_credit = 1'b0;
      send_req(make_pkt(CMD_READ, addr, src, '0));
      wait_resp(1'b0);
      check_resp(CMD_RESP_READ, addr, src, data);
      resp_credit = 1'b1;                           // Hand back the two still out
      repeat (2) @(negedge clk);
      resp_credit = 1'b0;
   endtask

   task automatic send_ignored(input umi_cmd_t code, input umi_addr_t addr);
      send_req(make_pkt(code, addr, umi_addr_t'($urandom()), ~model_mem[addr[7:2]]));
      repeat (5)
      begin
         @(negedge clk);
         if (resp_valid)
            fail_run("Response sent for an invalid command");
      end
   endtask

   task automatic test_invalid();
      umi_addr_t addr;
      addr = word_addr(12);
      post_write(addr, umi_data_t'($urandom()));
      send_ignored(umi_cmd_t'(7'h7f), addr);        // Unlisted code
      send_ignored(CMD_RESP_ACK, addr);             // Response type as request
      read_check(addr, 1'b1);
   endtask

   initial
   begin
      void'($urandom(38));
      nreset       = 1'b0;
      req_valid    = 1'b0;
      req_packet   = '0;
      resp_credit  = 1'b0;
      accept_cycle = 0;
      repeat (RESET_CYCLES) @(negedge clk);
      nreset = 1'b1;
      #1;
      if (req_ready || resp_valid)
         fail_run("Link signals high before the first edge after reset");
      test_write_read();
      test_ack_write();
      test_atomic(CMD_ATOMIC_ADD, 33);
      test_atomic(CMD_ATOMIC_SWAP, 40);
      test_backpressure();
      test_invalid();
      $display("Verification passed");
      $finish;
   end

endmodule

// File: build.f
+incdir+source
source/umi_pkt_pkg.sv
source/umi_ctrl_pkg.sv
source/umi_request_decode.sv
source/umi_credit_counter.sv
source/umi_endpoint_fsm.sv
source/umi_atomic_mem.sv
source/umi_response_pack.sv
source/umi_endpoint.sv
dv/tb_umi_endpoint.sv

// File: run.sh
#!/bin/sh
# Build and run the endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f build.f --top-module tb_umi_endpoint -Mdir obj_dir -o tb_umi_endpoint
if [ $? -ne 0 ]; then
   echo "Compile step failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_umi_endpoint 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Verification passed"; then
   exit 0
fi
echo "Pass line not found in the simulation output"
exit 1
